// File: Makefile
# Verilator build and run for the decode unit testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dec_top
FILELIST = dec_top.f
OBJ_DIR  = obj_dir
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# simulator output is printed, then searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dec_top.f
+incdir+include
source/dec_pkg.sv
source/dec_ifs.sv
source/dec_pipe_stage.sv
source/dec_decode_ctl.sv
source/dec_nbload_ctl.sv
source/dec_gpr_ctl.sv
source/dec_dbg_wb.sv
source/dec_top.sv
verif/dec_top_properties.sv
verif/tb_dec_top.sv

// File: include/dec_consts.svh
//******************************
// decode unit constants
// register file size and widths
// non-blocking load tag sizing
// rv32 major opcode values
//******************************
`ifndef DEC_CONSTS_SVH
`define DEC_CONSTS_SVH

`define DEC_XLEN          32          // data width
`define DEC_NREGS         32          // architectural registers
`define DEC_RADDR_W       5           // register address width

`define DEC_NBLOAD_DEPTH  4           // outstanding load tags
`define DEC_NBTAG_W       2           // load tag width

// major opcodes, instr[6:0]
`define DEC_OPC_OP_IMM    7'b0010011
`define DEC_OPC_OP        7'b0110011
`define DEC_OPC_LUI       7'b0110111
`define DEC_OPC_LOAD      7'b0000011
`define DEC_OPC_STORE     7'b0100011
`define DEC_OPC_BRANCH    7'b1100011
`define DEC_OPC_JAL       7'b1101111

`endif

// File: source/dec_dbg_wb.sv
//******************************
// dec_dbg_wb
// wishbone classic slave
// debug register read/write
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_dbg_wb (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`DEC_RADDR_W-1:0]  wb_adr,     // register number
   input  logic [`DEC_XLEN-1:0]     wb_wdata,
   output logic [`DEC_XLEN-1:0]     wb_rdata,
   output logic                     wb_ack,     // one cycle after grant
   dbg_gpr_if.master                dbg
);

   logic                 ack_q;
   logic [`DEC_XLEN-1:0] rdata_q;              // value at grant

   // no new request in the ack cycle, master drops stb after it
   assign dbg.req   = wb_cyc & wb_stb & ~ack_q;
   assign dbg.we    = wb_we;
   assign dbg.addr  = wb_adr;
   assign dbg.wdata = wb_wdata;

   assign wb_ack   = ack_q;
   assign wb_rdata = rdata_q;

   always_ff @(posedge clk) begin
      if (reset) ack_q <= 1'b0;
      else       ack_q <= dbg.grant;           // single cycle pulse
   end

   always_ff @(posedge clk) begin
      if (dbg.grant) rdata_q <= dbg.rdata;
   end

endmodule

`default_nettype wire

// File: source/dec_decode_ctl.sv
//******************************
// dec_decode_ctl
// opcode to class, immediates
// operand read, hazard stall
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_decode_ctl (
   input  dec_pkg::fetch_pkt_t      instr,
   input  logic                     in_valid,
   output logic                     in_ready,
   gpr_rd_if.dec                    gpr,
   input  logic [`DEC_NREGS-1:0]    busy_regs,  // rds of busy load tags
   input  logic                     tag_free,   // a load tag is available
   input  logic [`DEC_NBTAG_W-1:0]  alloc_tag,  // tag a load would take
   output logic                     load_go,    // load leaves decode
   output logic [`DEC_RADDR_W-1:0]  alloc_rd,
   output dec_pkg::dec_pkt_t        pkt,
   output logic                     pkt_valid,
   input  logic                     pkt_ready
);

   logic [31:0]             ins;
   logic [`DEC_RADDR_W-1:0] rs1, rs2, rd;
   logic                    use_rs1, use_rs2, rd_en, is_load;
   logic [`DEC_XLEN-1:0]    imm_i, imm_s, imm_b, imm_u, imm_j;
   logic                    stall;
   dec_pkg::dec_class_t     cls;
   logic [`DEC_XLEN-1:0]    imm;

   assign ins = instr.instr;
   assign rs1 = ins[19:15];
   assign rs2 = ins[24:20];
   assign rd  = ins[11:7];

   assign imm_i = {{20{ins[31]}}, ins[31:20]};
   assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
   assign imm_u = {ins[31:12], 12'b0};
   assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

   //******************************
   // opcode decode
   //******************************
   always_comb begin
      cls     = dec_pkg::CLS_ILLEGAL;  // unknown opcode uses nothing
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      rd_en   = 1'b0;
      imm     = '0;
      case (ins[6:0])
         `DEC_OPC_OP_IMM: begin cls = dec_pkg::CLS_ALU;    use_rs1 = 1'b1; rd_en = 1'b1; imm = imm_i; end
         `DEC_OPC_OP:     begin cls = dec_pkg::CLS_ALU;    use_rs1 = 1'b1; use_rs2 = 1'b1; rd_en = 1'b1; end
         `DEC_OPC_LUI:    begin cls = dec_pkg::CLS_ALU;    rd_en = 1'b1; imm = imm_u; end
         `DEC_OPC_LOAD:   begin cls = dec_pkg::CLS_LOAD;   use_rs1 = 1'b1; rd_en = 1'b1; imm = imm_i; end
         `DEC_OPC_STORE:  begin cls = dec_pkg::CLS_STORE;  use_rs1 = 1'b1; use_rs2 = 1'b1; imm = imm_s; end
         `DEC_OPC_BRANCH: begin cls = dec_pkg::CLS_BRANCH; use_rs1 = 1'b1; use_rs2 = 1'b1; imm = imm_b; end
         `DEC_OPC_JAL:    begin cls = dec_pkg::CLS_JUMP;   rd_en = 1'b1; imm = imm_j; end
         default: ;
      endcase
   end

   assign is_load = (cls == dec_pkg::CLS_LOAD);

   // raw or waw against an outstanding load, or no tag left for a load
   assign stall = (use_rs1 & busy_regs[rs1]) |
                  (use_rs2 & busy_regs[rs2]) |
                  (rd_en   & busy_regs[rd])  |
                  (is_load & ~tag_free);

   assign pkt_valid = in_valid & ~stall;
   assign in_ready  = pkt_ready & ~stall;     // buffer holds while stalled
   assign load_go   = in_valid & in_ready & is_load;
   assign alloc_rd  = rd;

   assign gpr.raddr1 = rs1;
   assign gpr.raddr2 = rs2;

   //******************************
   // packet assembly
   //******************************
   assign pkt.cls      = cls;
   assign pkt.rd       = rd_en ? rd : '0;
   assign pkt.rd_en    = rd_en;
   assign pkt.rs1_data = use_rs1 ? gpr.rdata1 : '0;
   assign pkt.rs2_data = use_rs2 ? gpr.rdata2 : '0;
   assign pkt.imm      = imm;
   assign pkt.load_tag = is_load ? alloc_tag : '0;

endmodule

`default_nettype wire

// File: source/dec_gpr_ctl.sv
//******************************
// dec_gpr_ctl
// 32x32 register file, x0 zero
// alu, load, divide write ports
// debug access in idle cycles
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_gpr_ctl (
   input  logic                     clk,
   input  logic                     reset,
   gpr_rd_if.rf                     gpr,         // operand reads
   dbg_gpr_if.slave                 dbg,         // debug access

   input  logic                     alu_wen,     // lowest priority
   input  logic [`DEC_RADDR_W-1:0]  alu_waddr,
   input  logic [`DEC_XLEN-1:0]     alu_wdata,
   input  logic                     load_wen,
   input  logic [`DEC_RADDR_W-1:0]  load_waddr,
   input  logic [`DEC_XLEN-1:0]     load_data,
   input  logic                     div_wen,     // highest priority
   input  logic [`DEC_RADDR_W-1:0]  div_waddr,
   input  logic [`DEC_XLEN-1:0]     div_wdata
);

   logic [`DEC_XLEN-1:0] regs [`DEC_NREGS];
   logic                 dbg_wen;

   //******************************
   // read side
   //******************************
   assign gpr.rdata1 = (gpr.raddr1 == '0) ? '0 : regs[gpr.raddr1];
   assign gpr.rdata2 = (gpr.raddr2 == '0) ? '0 : regs[gpr.raddr2];
   assign dbg.rdata  = (dbg.addr == '0)   ? '0 : regs[dbg.addr];

   // debug only gets a cycle with no core write
   assign dbg.grant = dbg.req & ~alu_wen & ~load_wen & ~div_wen;
   assign dbg_wen   = dbg.grant & dbg.we;

   //******************************
   // write side
   //******************************
   // later assignment wins, so order sets div > load > alu
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `DEC_NREGS; i++) begin
            regs[i] <= '0;             // reads zero after reset
         end
      end else begin
         if (alu_wen)  regs[alu_waddr]  <= alu_wdata;
         if (load_wen) regs[load_waddr] <= load_data;
         if (div_wen)  regs[div_waddr]  <= div_wdata;
         if (dbg_wen)  regs[dbg.addr]   <= dbg.wdata;   // exclusive with the above
      end
   end

endmodule

`default_nettype wire

// File: source/dec_ifs.sv
//******************************
// register file interfaces
//   gpr_rd_if   operand reads
//   dbg_gpr_if  debug access
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

// two combinational read ports, decode side drives addresses
interface gpr_rd_if;
   logic [`DEC_RADDR_W-1:0] raddr1;    // rs1 address
   logic [`DEC_RADDR_W-1:0] raddr2;    // rs2 address
   logic [`DEC_XLEN-1:0]    rdata1;    // rs1 data, x0 reads zero
   logic [`DEC_XLEN-1:0]    rdata2;    // rs2 data

   modport dec (
      output raddr1, raddr2,
      input  rdata1, rdata2
   );

   modport rf (
      input  raddr1, raddr2,
      output rdata1, rdata2
   );
endinterface

// debug register access, granted only in idle write cycles
interface dbg_gpr_if;
   logic                    req;       // access pending
   logic                    we;        // write when high
   logic [`DEC_RADDR_W-1:0] addr;
   logic [`DEC_XLEN-1:0]    wdata;
   logic                    grant;     // access done this cycle
   logic [`DEC_XLEN-1:0]    rdata;     // same cycle read data

   modport master (output req, we, addr, wdata, input grant, rdata);
   modport slave  (input req, we, addr, wdata, output grant, rdata);
endinterface

`default_nettype wire

// File: source/dec_nbload_ctl.sv
//******************************
// dec_nbload_ctl
// outstanding load tag table
// lowest free tag allocation
// busy rd mask, return writes
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_nbload_ctl (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     load_go,          // load leaves decode
   input  logic [`DEC_RADDR_W-1:0]  alloc_rd,         // its destination
   output logic [`DEC_NBTAG_W-1:0]  alloc_tag,        // lowest free tag
   output logic                     tag_free,
   output logic [`DEC_NREGS-1:0]    busy_regs,
   input  logic                     load_data_valid,  // load data back
   input  logic [`DEC_NBTAG_W-1:0]  load_data_tag,
   output logic                     load_wen,         // gpr write for return
   output logic [`DEC_RADDR_W-1:0]  load_waddr
);

   logic [`DEC_NBLOAD_DEPTH-1:0] tag_valid;                         // tag busy
   logic [`DEC_RADDR_W-1:0]      tag_rd [`DEC_NBLOAD_DEPTH];        // rd per tag

   assign tag_free = ~&tag_valid;

   always_comb begin
      alloc_tag = '0;
      busy_regs = '0;
      for (int i = `DEC_NBLOAD_DEPTH - 1; i >= 0; i--) begin
         if (!tag_valid[i]) alloc_tag = `DEC_NBTAG_W'(i);   // last hit is lowest
         if (tag_valid[i])  busy_regs[tag_rd[i]] = 1'b1;
      end
      busy_regs[0] = 1'b0;             // x0 never busy
   end

   // return of a busy tag writes its rd
   assign load_wen   = load_data_valid & tag_valid[load_data_tag];
   assign load_waddr = tag_rd[load_data_tag];

   always_ff @(posedge clk) begin
      if (reset) begin
         tag_valid <= '0;
      end else begin
         if (load_data_valid) tag_valid[load_data_tag] <= 1'b0;
         if (load_go)         tag_valid[alloc_tag]     <= 1'b1;  // only free tags
      end
   end

   always_ff @(posedge clk) begin
      if (load_go) tag_rd[alloc_tag] <= alloc_rd;
   end

endmodule

`default_nettype wire

// File: source/dec_pipe_stage.sv
//******************************
// dec_pipe_stage
// one valid/ready register slot
// payload type set per instance
//******************************
`timescale 1ns/1ps
`default_nettype none

module dec_pipe_stage #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     reset,

   input  logic     in_valid,          // upstream has data
   output logic     in_ready,          // slot can take data
   input  payload_t in_data,

   output logic     out_valid,         // slot holds data
   input  logic     out_ready,         // downstream takes it
   output payload_t out_data
);

   logic     valid_q;                  // slot occupied
   payload_t data_q;                   // held payload

   // empty slot, or the held entry drains this edge
   assign in_ready  = ~valid_q | out_ready;
   assign out_valid = valid_q;
   assign out_data  = data_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;          // refill or go empty
      end
   end

   // payload only moves on a transfer, so a held valid stays stable
   always_ff @(posedge clk) begin
      if (in_valid & in_ready) begin
         data_q <= in_data;
      end
   end

endmodule

`default_nettype wire

// File: source/dec_pkg.sv
//******************************
// decode unit types
// instruction class encoding
// fetch and decoded packets
//******************************
`default_nettype none

`include "dec_consts.svh"

package dec_pkg;

   // instruction class seen by execute
   typedef enum logic [2:0] {
      CLS_ALU     = 3'd0,               // op_imm, op, lui
      CLS_LOAD    = 3'd1,
      CLS_STORE   = 3'd2,
      CLS_BRANCH  = 3'd3,
      CLS_JUMP    = 3'd4,               // jal
      CLS_ILLEGAL = 3'd7                // unknown opcode
   } dec_class_t;

   // fetched instruction
   typedef struct packed {
      logic [31:0] instr;               // raw instruction word
   } fetch_pkt_t;

   // decoded packet handed to execute
   typedef struct packed {
      dec_class_t                  cls;       // instruction class
      logic [`DEC_RADDR_W-1:0]     rd;        // destination
      logic                        rd_en;     // rd written
      logic [`DEC_XLEN-1:0]        rs1_data;  // zero when rs1 unused
      logic [`DEC_XLEN-1:0]        rs2_data;  // zero when rs2 unused
      logic [`DEC_XLEN-1:0]        imm;       // sign extended immediate
      logic [`DEC_NBTAG_W-1:0]     load_tag;  // valid for loads only
   } dec_pkt_t;

endpackage

`default_nettype wire

// File: source/dec_top.sv
//******************************
// dec_top
// fetch buffer, decode, out stage
// load tags, register file
// wishbone debug access
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_top (
   input  logic                     clk,
   input  logic                     reset,
   // instruction path
   input  logic                     fetch_valid,
   input  logic [31:0]              fetch_instr,
   output logic                     fetch_ready,
   output logic                     dec_valid,
   input  logic                     dec_ready,
   output dec_pkg::dec_class_t      dec_class,
   output logic [`DEC_RADDR_W-1:0]  dec_rd,
   output logic                     dec_rd_en,
   output logic [`DEC_XLEN-1:0]     dec_rs1_data,
   output logic [`DEC_XLEN-1:0]     dec_rs2_data,
   output logic [`DEC_XLEN-1:0]     dec_imm,
   output logic [`DEC_NBTAG_W-1:0]  dec_load_tag,
   // register write ports
   input  logic                     alu_wen,
   input  logic [`DEC_RADDR_W-1:0]  alu_waddr,
   input  logic [`DEC_XLEN-1:0]     alu_wdata,
   input  logic                     load_data_valid,
   input  logic [`DEC_NBTAG_W-1:0]  load_data_tag,
   input  logic [`DEC_XLEN-1:0]     load_data,
   input  logic                     div_wen,
   input  logic [`DEC_RADDR_W-1:0]  div_waddr,
   input  logic [`DEC_XLEN-1:0]     div_wdata,
   // wishbone debug
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  logic [`DEC_RADDR_W-1:0]  wb_adr,
   input  logic [`DEC_XLEN-1:0]     wb_wdata,
   output logic [`DEC_XLEN-1:0]     wb_rdata,
   output logic                     wb_ack
);

   dec_pkg::fetch_pkt_t          buf_data;
   dec_pkg::dec_pkt_t            dec_pkt, out_pkt;
   logic                         buf_valid, buf_ready, pkt_valid, pkt_ready;
   logic [`DEC_NREGS-1:0]        busy_regs;
   logic                         tag_free, load_go, load_wen;
   logic [`DEC_NBTAG_W-1:0]      alloc_tag;
   logic [`DEC_RADDR_W-1:0]      alloc_rd, load_waddr;

   gpr_rd_if  gpr_rd ();
   dbg_gpr_if dbg_gpr ();

   dec_pipe_stage #(.payload_t(dec_pkg::fetch_pkt_t)) fetch_buf (
      .clk, .reset, .in_valid(fetch_valid), .in_ready(fetch_ready),
      .in_data(dec_pkg::fetch_pkt_t'(fetch_instr)),
      .out_valid(buf_valid), .out_ready(buf_ready), .out_data(buf_data));

   dec_decode_ctl decode (
      .instr(buf_data), .in_valid(buf_valid), .in_ready(buf_ready), .gpr(gpr_rd),
      .busy_regs, .tag_free, .alloc_tag, .load_go, .alloc_rd,
      .pkt(dec_pkt), .pkt_valid, .pkt_ready);

   dec_pipe_stage #(.payload_t(dec_pkg::dec_pkt_t)) out_stage (
      .clk, .reset, .in_valid(pkt_valid), .in_ready(pkt_ready), .in_data(dec_pkt),
      .out_valid(dec_valid), .out_ready(dec_ready), .out_data(out_pkt));

   dec_nbload_ctl nbload (
      .clk, .reset, .load_go, .alloc_rd, .alloc_tag, .tag_free, .busy_regs,
      .load_data_valid, .load_data_tag, .load_wen, .load_waddr);

   dec_gpr_ctl arf (
      .clk, .reset, .gpr(gpr_rd), .dbg(dbg_gpr),
      .alu_wen, .alu_waddr, .alu_wdata, .load_wen, .load_waddr, .load_data,
      .div_wen, .div_waddr, .div_wdata);

   dec_dbg_wb dbg_wb (
      .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_wdata,
      .wb_rdata, .wb_ack, .dbg(dbg_gpr));

   // output stage fields to plain ports
   assign dec_class    = out_pkt.cls;
   assign dec_rd       = out_pkt.rd;
   assign dec_rd_en    = out_pkt.rd_en;
   assign dec_rs1_data = out_pkt.rs1_data;
   assign dec_rs2_data = out_pkt.rs2_data;
   assign dec_imm      = out_pkt.imm;
   assign dec_load_tag = out_pkt.load_tag;

endmodule

`default_nettype wire

// File: verif/dec_top_properties.sv
//******************************
// dec_top_properties
// packet hold under back-pressure
// single cycle wishbone ack
// no decode transfer on a hazard
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module dec_top_properties (
   input logic                    clk,
   input logic                    reset,
   input logic                    dec_valid,
   input logic                    dec_ready,
   input dec_pkg::dec_pkt_t       out_pkt,      // output stage contents
   input logic                    wb_ack,
   input logic                    buf_valid,    // fetch buffer occupied
   input logic [31:0]             buf_instr,
   input logic [`DEC_NREGS-1:0]   busy_regs,    // rds of busy load tags
   input logic                    tag_free,
   input logic                    pkt_valid     // decode offers a packet
);

   logic [6:0] opc;
   logic       reads_rs1;
   logic       hazard;

   assign opc       = buf_instr[6:0];
   assign reads_rs1 = opc inside {`DEC_OPC_OP_IMM, `DEC_OPC_OP, `DEC_OPC_LOAD,
                                  `DEC_OPC_STORE, `DEC_OPC_BRANCH};
   // raw on rs1, or a load with every tag in use
   assign hazard = buf_valid & ((reads_rs1 & busy_regs[buf_instr[19:15]]) |
                                ((opc == `DEC_OPC_LOAD) & ~tag_free));

   hold_pkt: assert property (@(posedge clk) disable iff (reset)
      dec_valid && !dec_ready |=> dec_valid && $stable(out_pkt))
      else $error("decoded packet changed while held by back-pressure");

   ack_pulse: assert property (@(posedge clk) disable iff (reset)
      wb_ack |=> !wb_ack)
      else $error("wishbone ack high for more than one cycle");

   no_hazard_xfer: assert property (@(posedge clk) disable iff (reset)
      hazard |-> !pkt_valid)
      else $error("decode offered a packet during a load hazard");

endmodule

bind dec_top dec_top_properties props (
   .clk, .reset, .dec_valid, .dec_ready, .out_pkt, .wb_ack, .buf_valid,
   .buf_instr(buf_data), .busy_regs, .tag_free, .pkt_valid);

`default_nettype wire

// File: verif/tb_dec_top.sv
//******************************
// tb_dec_top
// wishbone, random decode, back-pressure
// write port priority, load tag stalls
// reference model, checker, watchdog
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "dec_consts.svh"

module tb_dec_top;

   localparam int CLK_NS = 8;
   localparam int N_RAND = 80;                                  // random instructions
   localparam int N_OPS  = 2 * `DEC_NREGS + N_RAND + 40;        // all issued operations

   logic                    clk, reset;
   logic                    fetch_valid, fetch_ready, dec_valid, dec_ready;
   logic [31:0]             fetch_instr;
   dec_pkg::dec_class_t     dec_class;
   logic [`DEC_RADDR_W-1:0] dec_rd;
   logic                    dec_rd_en;
   logic [`DEC_XLEN-1:0]    dec_rs1_data, dec_rs2_data, dec_imm;
   logic [`DEC_NBTAG_W-1:0] dec_load_tag;
   logic                    alu_wen, div_wen, load_data_valid;
   logic [`DEC_RADDR_W-1:0] alu_waddr, div_waddr;
   logic [`DEC_XLEN-1:0]    alu_wdata, div_wdata, load_data;
   logic [`DEC_NBTAG_W-1:0] load_data_tag;
   logic                    wb_cyc, wb_stb, wb_we, wb_ack;
   logic [`DEC_RADDR_W-1:0] wb_adr;
   logic [`DEC_XLEN-1:0]    wb_wdata, wb_rdata;

   logic [`DEC_NREGS-1:0][`DEC_XLEN-1:0] model_regs;  // x0 never written
   dec_pkg::dec_pkt_t       exp_q[$];                 // packets in issue order
   dec_pkg::dec_pkt_t       exp_pkt;
   int                      n_pushed, n_seen;
   logic                    bp_on;                    // random dec_ready
   logic [`DEC_NBTAG_W-1:0] last_load_tag;            // as reported by DUT
   string                   test_name;

   dec_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(CLK_NS * (N_OPS * 20 + 200));
      $display("watchdog expired before the tests finished");
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      dec_ready = 1'b1;
      forever begin
         @(negedge clk);
         dec_ready = bp_on ? (($urandom % 4) != 0) : 1'b1;   // ready 3 of 4 cycles
      end
   end

   //******************************
   // reference model and checks
   //******************************
   task automatic check(input string what, input logic [31:0] expv,
                        input logic [31:0] act);
      if (act !== expv) begin
         $display("ERROR: %s %s expected %h actual %h", test_name, what, expv, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic dec_pkg::dec_pkt_t ref_decode(
      input logic [31:0]                          w,
      input logic [`DEC_NREGS-1:0][`DEC_XLEN-1:0] regs,
      input logic [`DEC_NBTAG_W-1:0]              tag);
      dec_pkg::dec_pkt_t p;
      logic [2:0]        uses;                     // rd, rs1, rs2
      p     = '0;
      p.cls = dec_pkg::CLS_ILLEGAL;
      uses  = 3'b000;
      case (w[6:0])
         `DEC_OPC_OP_IMM: begin
            p.cls = dec_pkg::CLS_ALU;
            uses  = 3'b110;
            p.imm = 32'($signed(w[31:20]));
         end
         `DEC_OPC_OP: begin
            p.cls = dec_pkg::CLS_ALU;
            uses  = 3'b111;
         end
         `DEC_OPC_LUI: begin
            p.cls = dec_pkg::CLS_ALU;
            uses  = 3'b100;
            p.imm = {w[31:12], 12'h000};
         end
         `DEC_OPC_LOAD: begin
            p.cls      = dec_pkg::CLS_LOAD;
            uses       = 3'b110;
            p.imm      = 32'($signed(w[31:20]));
            p.load_tag = tag;
         end
         `DEC_OPC_STORE: begin
            p.cls = dec_pkg::CLS_STORE;
            uses  = 3'b011;
            p.imm = 32'($signed({w[31:25], w[11:7]}));
         end
         `DEC_OPC_BRANCH: begin
            p.cls = dec_pkg::CLS_BRANCH;
            uses  = 3'b011;
            p.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
         end
         `DEC_OPC_JAL: begin
            p.cls = dec_pkg::CLS_JUMP;
            uses  = 3'b100;
            p.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
         end
         default: ;                                // illegal, nothing used
      endcase
      p.rd_en    = uses[2];
      p.rd       = uses[2] ? w[11:7] : '0;
      p.rs1_data = uses[1] ? regs[w[19:15]] : '0;
      p.rs2_data = uses[0] ? regs[w[24:20]] : '0;
      return p;
   endfunction

   // compare every output transfer against the queue head
   initial begin
      n_seen        = 0;
      last_load_tag = '0;
      forever begin
         @(posedge clk);
         if (!reset && dec_valid && dec_ready) begin
            if (exp_q.size() == 0) begin
               $display("decode produced a packet that no issued instruction explains");
               $display("TEST RESULT: FAIL");
               $fatal(1, "unexpected packet");
            end else begin
               exp_pkt = exp_q.pop_front();
               check("class", 32'(exp_pkt.cls), 32'(dec_class));
               check("rd", 32'(exp_pkt.rd), 32'(dec_rd));
               check("rd_en", 32'(exp_pkt.rd_en), 32'(dec_rd_en));
               check("rs1 data", exp_pkt.rs1_data, dec_rs1_data);
               check("rs2 data", exp_pkt.rs2_data, dec_rs2_data);
               check("imm", exp_pkt.imm, dec_imm);
               check("load tag", 32'(exp_pkt.load_tag), 32'(dec_load_tag));
               if (dec_class == dec_pkg::CLS_LOAD) last_load_tag = dec_load_tag;
               n_seen++;
            end
         end
      end
   end

   //******************************
   // stimulus tasks
   //******************************
   function automatic logic [31:0] enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {7'b0, rs2, rs1, 3'b0, rd, opc};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [4:0] rd, input logic [6:0] opc);
      return {imm, rs1, 3'b0, rd, opc};
   endfunction

   task automatic send_instr(input logic [31:0] w);
      @(negedge clk);
      fetch_valid = 1'b1;
      fetch_instr = w;
      do @(posedge clk); while (!fetch_ready);     // wait for the buffer to take it
      @(negedge clk);
      fetch_valid = 1'b0;
   endtask

   task automatic expect_pkt(input logic [31:0] w, input logic [`DEC_NBTAG_W-1:0] tag);
      exp_q.push_back(ref_decode(w, model_regs, tag));
      n_pushed++;
   endtask

   task automatic issue(input logic [31:0] w, input logic [`DEC_NBTAG_W-1:0] tag);
      expect_pkt(w, tag);
      send_instr(w);
   endtask

   task automatic drain();
      while (n_seen != n_pushed) @(negedge clk);
   endtask

   task automatic wb_access(input logic we, input logic [4:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_wdata = wdata;
      do @(negedge clk); while (!wb_ack);
      rdata  = wb_rdata;
      wb_cyc = 1'b0;                               // classic cycle ends on ack
      wb_stb = 1'b0;
   endtask

   task automatic core_write(input logic alu_en, input logic [4:0] alu_a,
                             input logic [31:0] alu_d, input logic div_en,
                             input logic [4:0] div_a, input logic [31:0] div_d);
      @(negedge clk);
      alu_wen   = alu_en;
      alu_waddr = alu_a;
      alu_wdata = alu_d;
      div_wen   = div_en;
      div_waddr = div_a;
      div_wdata = div_d;
      @(negedge clk);
      alu_wen = 1'b0;
      div_wen = 1'b0;
      if (alu_en && alu_a != 0) model_regs[alu_a] = alu_d;
      if (div_en && div_a != 0) model_regs[div_a] = div_d;   // divide beats alu
   endtask

   task automatic load_return(input logic [1:0] tag, input logic [31:0] d,
                              input logic alu_en, input logic div_en,
                              input logic [4:0] waddr);
      @(negedge clk);
      load_data_valid = 1'b1;
      load_data_tag   = tag;
      load_data       = d;
      alu_wen         = alu_en;
      alu_waddr       = waddr;
      alu_wdata       = ~d;                        // loses on a collision
      div_wen         = div_en;
      div_waddr       = waddr;
      div_wdata       = ~d;                        // wins on a collision
      @(negedge clk);
      load_data_valid = 1'b0;
      alu_wen         = 1'b0;
      div_wen         = 1'b0;
   endtask

   //******************************
   // test sequence
   //******************************
   initial begin
      logic [31:0] w, r, d;
      int          sel;
      void'($urandom(76743));
      {fetch_valid, fetch_instr, alu_wen, alu_waddr, alu_wdata} = '0;
      {div_wen, div_waddr, div_wdata, load_data_valid, load_data_tag, load_data} = '0;
      {wb_cyc, wb_stb, wb_we, wb_adr, wb_wdata} = '0;
      model_regs = '0;
      n_pushed   = 0;
      bp_on      = 1'b0;
      test_name  = "reset";
      reset      = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      test_name = "wishbone";
      for (int i = 0; i < `DEC_NREGS; i++) begin
         w = $urandom;
         wb_access(1'b1, 5'(i), w, r);
         if (i != 0) model_regs[i] = w;             // x0 stays zero
      end
      for (int i = 0; i < `DEC_NREGS; i++) begin
         wb_access(1'b0, 5'(i), '0, r);
         check("readback", model_regs[i], r);
      end

      test_name = "random decode";
      bp_on     = 1'b1;
      for (int n = 0; n < N_RAND; n++) begin
         w   = $urandom;
         sel = $urandom % 7;
         case (sel)
            0: w[6:0] = `DEC_OPC_OP_IMM;
            1: w[6:0] = `DEC_OPC_OP;
            2: w[6:0] = `DEC_OPC_LUI;
            3: w[6:0] = `DEC_OPC_STORE;
            4: w[6:0] = `DEC_OPC_BRANCH;
            5: w[6:0] = `DEC_OPC_JAL;
            default: w[6:0] = {w[11:7], 2'b00};    // no valid opcode ends in 00
         endcase
         issue(w, '0);
      end
      drain();
      bp_on = 1'b0;

      test_name = "write ports";
      core_write(1'b1, 5'd5, $urandom, 1'b1, 5'd5, $urandom);   // same register
      core_write(1'b1, 5'd6, $urandom, 1'b1, 5'd7, $urandom);
      issue(enc_r(5'd6, 5'd5, 5'd1, `DEC_OPC_OP), '0);
      issue(enc_r(5'd5, 5'd7, 5'd2, `DEC_OPC_STORE), '0);
      drain();

      test_name = "load hazard";
      issue(enc_i(12'($urandom), 5'd3, 5'd9, `DEC_OPC_LOAD), 2'd0);
      w = enc_r(5'd3, 5'd9, 5'd4, `DEC_OPC_OP);    // reads the load rd
      send_instr(w);
      repeat (8) @(negedge clk);
      check("user held", n_pushed, n_seen);
      d              = $urandom;
      model_regs[9]  = d;                          // load beats the alu write
      expect_pkt(w, '0);
      load_return(last_load_tag, d, 1'b1, 1'b0, 5'd9);
      drain();

      test_name = "load tags";
      for (int t = 0; t < `DEC_NBLOAD_DEPTH; t++) begin
         issue(enc_i(12'($urandom), 5'd0, 5'(16 + t), `DEC_OPC_LOAD), 2'(t));
      end
      w = enc_i(12'($urandom), 5'd0, 5'd20, `DEC_OPC_LOAD);
      send_instr(w);
      repeat (8) @(negedge clk);
      check("tags full", n_pushed, n_seen);
      d              = $urandom;
      model_regs[16] = d;
      expect_pkt(w, 2'd0);                         // returned tag is lowest free
      load_return(2'd0, d, 1'b0, 1'b0, '0);
      drain();
      for (int t = 1; t < `DEC_NBLOAD_DEPTH; t++) begin
         d                  = $urandom;
         model_regs[16 + t] = (t == 1) ? ~d : d;   // divide beats the load on x17
         load_return(2'(t), d, 1'b0, t == 1, 5'(16 + t));
      end
      d              = $urandom;
      model_regs[20] = d;
      load_return(2'd0, d, 1'b0, 1'b0, '0);
      issue(enc_r(5'd20, 5'd17, 5'd0, `DEC_OPC_BRANCH), '0);
      drain();

      if (n_seen == n_pushed && exp_q.size() == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         $display("ERROR: %s expected %0d packets actual %0d", test_name, n_pushed, n_seen);
         $display("TEST RESULT: FAIL");
         $fatal(1, "missing packets");
      end
   end

endmodule

`default_nettype wire
